// File: src/video_timing_pkg.sv
// Scan position carried from the timing generator to the fetch and pixel stages.
// Counter widths allow up to 1024 clocks per line and 512 lines per frame.
`default_nettype none

package video_timing_pkg;

    parameter int H_CNT_W = 10;
    parameter int V_CNT_W = 9;

    typedef logic [H_CNT_W-1:0] hcount_t;
    typedef logic [V_CNT_W-1:0] vcount_t;

    typedef struct packed {
        hcount_t h;          // pixel counter incl. blanking
        vcount_t v;          // line counter incl. blanking
        logic    de;
        logic    hsync;      // already at output polarity
        logic    vsync;
        hcount_t fetch_col;  // leads the visible column by one tile
        logic    fetch_en;
        vcount_t row;        // visible line
    } scan_pos_t;

endpackage

`default_nettype wire

// File: src/tile_pkg.sv
// Tile plane memory map, fetch slot encoding and pixel types.
// Map rows are 64 tiles wide regardless of the visible width.
`default_nettype none

package tile_pkg;

    parameter int VRAM_AW        = 14;
    parameter int MAP_STRIDE     = 64;    // tiles per map row
    parameter int PALETTE_BASE   = 1024;  // word VRAM
    parameter int COLOR_MAP_BASE = 2048;  // byte VRAM
    parameter int WORDS_PER_TILE = 4;     // two rows per pattern word

    typedef logic [VRAM_AW-1:0] vram_addr_t;

    // one slot per pixel clock, eight per tile
    typedef enum logic [2:0] {
        PH_MAP     = 3'd0,
        PH_PATTERN = 3'd1,
        PH_COLOR   = 3'd2,
        PH_PALETTE = 3'd3,
        PH_IDLE4   = 3'd4,
        PH_IDLE5   = 3'd5,
        PH_IDLE6   = 3'd6,
        PH_IDLE7   = 3'd7
    } fetch_phase_e;

    typedef struct packed {
        logic [2:0] r;
        logic [2:0] g;
        logic [1:0] b;
    } rgb332_t;

    // element k is pixel k of the tile
    typedef rgb332_t [7:0] tile_line_t;

endpackage

`default_nettype wire

// File: src/video_timing.sv
// Free-running raster counters. Needs H_FP and V_FP of at least 1 and
// H_FP + H_SYNC + H_BP of at least 8 so the fetch window fits in blanking.
// H_RES must be a multiple of 8.
`timescale 1ns/1ps
`default_nettype none

module video_timing #(
    parameter int H_RES  = 320,
    parameter int V_RES  = 240,
    parameter int H_FP   = 23,
    parameter int H_SYNC = 28,
    parameter int H_BP   = 45,
    parameter int V_FP   = 6,
    parameter int V_SYNC = 3,
    parameter int V_BP   = 20,
    parameter bit H_POL  = 1'b0,
    parameter bit V_POL  = 1'b0
) (
    input  wire                         i_rst_n,
    input  wire                         vga_clk,
    output video_timing_pkg::scan_pos_t o_pos
);

    localparam int HS_STA    = H_FP - 1;        // first pixel is 0
    localparam int HS_END    = HS_STA + H_SYNC;
    localparam int HA_STA    = HS_END + H_BP;
    localparam int LINE      = HA_STA + H_RES;  // last pixel of the line
    localparam int VS_STA    = V_FP - 1;
    localparam int VS_END    = VS_STA + V_SYNC;
    localparam int VA_STA    = VS_END + V_BP;
    localparam int FRAME     = VA_STA + V_RES;  // last line of the frame
    localparam int FETCH_OFS = HA_STA + 1 - 8;

    video_timing_pkg::hcount_t h_nxt;
    video_timing_pkg::vcount_t v_nxt;

    function automatic video_timing_pkg::scan_pos_t make_pos(
        input video_timing_pkg::hcount_t h,
        input video_timing_pkg::vcount_t v
    );
        video_timing_pkg::scan_pos_t p;
        logic h_in_sync;
        logic v_in_sync;
        logic v_act;
        h_in_sync   = (int'(h) > HS_STA) && (int'(h) <= HS_END);
        v_in_sync   = (int'(v) > VS_STA) && (int'(v) <= VS_END);
        v_act       = int'(v) > VA_STA;
        p.h         = h;
        p.v         = v;
        p.de        = (int'(h) > HA_STA) && v_act;
        p.hsync     = H_POL ? h_in_sync : ~h_in_sync;
        p.vsync     = V_POL ? v_in_sync : ~v_in_sync;
        p.fetch_col = h - video_timing_pkg::hcount_t'(FETCH_OFS);  // wraps high before window
        p.fetch_en  = (p.fetch_col < video_timing_pkg::hcount_t'(H_RES)) && v_act;
        p.row       = v - video_timing_pkg::vcount_t'(VA_STA + 1);
        return p;
    endfunction

    always_comb begin
        h_nxt = o_pos.h + 1'b1;
        v_nxt = o_pos.v;
        if (o_pos.h == video_timing_pkg::hcount_t'(LINE)) begin
            h_nxt = '0;
            v_nxt = (o_pos.v == video_timing_pkg::vcount_t'(FRAME)) ? '0 : o_pos.v + 1'b1;
        end
    end

    always_ff @(posedge vga_clk) begin
        if (!i_rst_n) begin
            o_pos <= make_pos('0, '0);
        end else begin
            o_pos <= make_pos(h_nxt, v_nxt);
        end
    end

endmodule

`default_nettype wire

// File: src/tile_fetcher.sv
// Background tile fetch, one tile per eight clocks, slots 4 to 7 idle.
// VRAM reads are synchronous: q belongs to the address of the previous clock.
// The pattern and palette addresses follow the arriving byte in the same clock.
`timescale 1ns/1ps
`default_nettype none

module tile_fetcher (
    input  wire                              vga_clk,
    input  wire                              i_rst_n,
    input  wire video_timing_pkg::scan_pos_t i_pos,
    output tile_pkg::vram_addr_t             o_vram8_addr,
    input  wire [7:0]                        i_vram8_q,
    output tile_pkg::vram_addr_t             o_vram32_addr,
    input  wire [31:0]                       i_vram32_q,
    output tile_pkg::tile_line_t             o_line,
    output logic                             o_load,
    output logic                             o_swap
);

    tile_pkg::fetch_phase_e phase;
    tile_pkg::fetch_phase_e prev_phase;
    logic                   prev_en;
    logic [7:0]             tile_q;
    logic [7:0]             color_q;
    logic [7:0]             tile_idx;
    logic [7:0]             color_idx;
    logic [15:0]            half;
    logic [15:0]            pat_nxt;
    logic [15:0]            pat_bits;   // pixel k code in bits 2k+1:2k
    tile_pkg::vram_addr_t   map_off;

    assign phase = tile_pkg::fetch_phase_e'(i_pos.fetch_col[2:0]);

    always_ff @(posedge vga_clk) begin
        if (!i_rst_n) begin
            prev_phase <= tile_pkg::PH_MAP;
            prev_en    <= 1'b0;
        end else begin
            prev_phase <= phase;   // tells which read is arriving
            prev_en    <= i_pos.fetch_en;
        end
    end

    // odd rows use the low half, both halves bit-reversed
    always_comb begin
        half = i_pos.row[0] ? i_vram32_q[15:0] : i_vram32_q[31:16];
        for (int j = 0; j < 16; j++) begin
            pat_nxt[j] = half[15-j];
        end
    end

    always_ff @(posedge vga_clk) begin
        if (prev_en) begin
            case (prev_phase)
                tile_pkg::PH_MAP:     tile_q   <= i_vram8_q;
                tile_pkg::PH_PATTERN: pat_bits <= pat_nxt;
                tile_pkg::PH_COLOR:   color_q  <= i_vram8_q;
                default: ;
            endcase
        end
    end

    // forward the byte while it is arriving
    assign tile_idx  = (prev_en && prev_phase == tile_pkg::PH_MAP) ? i_vram8_q : tile_q;
    assign color_idx = (prev_en && prev_phase == tile_pkg::PH_COLOR) ? i_vram8_q : color_q;

    assign map_off = tile_pkg::vram_addr_t'(i_pos.row[8:3])
                   * tile_pkg::vram_addr_t'(tile_pkg::MAP_STRIDE)
                   + tile_pkg::vram_addr_t'(i_pos.fetch_col[9:3]);

    always_comb begin
        o_vram8_addr  = '0;
        o_vram32_addr = '0;
        if (i_pos.fetch_en) begin
            case (phase)
                tile_pkg::PH_MAP: o_vram8_addr = map_off;
                tile_pkg::PH_PATTERN: begin
                    o_vram32_addr = tile_pkg::vram_addr_t'(tile_idx)
                                  * tile_pkg::vram_addr_t'(tile_pkg::WORDS_PER_TILE)
                                  + tile_pkg::vram_addr_t'(i_pos.row[2:1]);
                end
                tile_pkg::PH_COLOR: begin
                    o_vram8_addr = tile_pkg::vram_addr_t'(tile_pkg::COLOR_MAP_BASE) + map_off;
                end
                tile_pkg::PH_PALETTE: begin
                    o_vram32_addr = tile_pkg::vram_addr_t'(tile_pkg::PALETTE_BASE)
                                  + tile_pkg::vram_addr_t'(color_idx);
                end
                default: ;
            endcase
        end
    end

    // code 0 takes the top palette byte
    always_comb begin
        for (int k = 0; k < 8; k++) begin
            o_line[k] = tile_pkg::rgb332_t'(i_vram32_q[8*(3 - int'(pat_bits[2*k +: 2])) +: 8]);
        end
    end

    assign o_load = prev_en && (prev_phase == tile_pkg::PH_PALETTE);  // palette word in PH_IDLE4
    assign o_swap = i_pos.fetch_en && (phase == tile_pkg::PH_IDLE7);

endmodule

`default_nettype wire

// File: src/tile_line_buffer.sv
// Two-stage tile buffer: next is filled while current is on screen.
// Load and swap are expected in different clocks.
`timescale 1ns/1ps
`default_nettype none

module tile_line_buffer (
    input  wire                       vga_clk,
    input  wire                       i_rst_n,
    input  wire tile_pkg::tile_line_t i_line,
    input  wire                       i_load,
    input  wire                       i_swap,
    output tile_pkg::tile_line_t      o_cur
);

    tile_pkg::tile_line_t next_line;
    tile_pkg::tile_line_t cur_line;

    always_ff @(posedge vga_clk) begin
        if (!i_rst_n) begin
            next_line <= '0;
            cur_line  <= '0;
        end else begin
            if (i_load) begin
                next_line <= i_line;
            end
            if (i_swap) begin
                cur_line <= next_line;  // visible from the next clock
            end
        end
    end

    assign o_cur = cur_line;

endmodule

`default_nettype wire

// File: src/pixel_out.sv
// Output stage. Colour and syncs leave one clock after the scan position.
`timescale 1ns/1ps
`default_nettype none

module pixel_out #(
    parameter bit H_POL = 1'b0,
    parameter bit V_POL = 1'b0
) (
    input  wire                              vga_clk,
    input  wire                              i_rst_n,
    input  wire video_timing_pkg::scan_pos_t i_pos,
    input  wire tile_pkg::tile_line_t        i_cur,
    output logic                             o_hsync,
    output logic                             o_vsync,
    output logic                             o_de,
    output tile_pkg::rgb332_t                o_rgb
);

    tile_pkg::rgb332_t pix;

    // fetch_col mod 8 equals visible column mod 8
    assign pix = i_pos.de ? i_cur[i_pos.fetch_col[2:0]] : '0;

    always_ff @(posedge vga_clk) begin
        if (!i_rst_n) begin
            o_hsync <= ~H_POL;
            o_vsync <= ~V_POL;
            o_de    <= 1'b0;
            o_rgb   <= '0;
        end else begin
            o_hsync <= i_pos.hsync;
            o_vsync <= i_pos.vsync;
            o_de    <= i_pos.de;
            o_rgb   <= pix;
        end
    end

endmodule

`default_nettype wire

// File: src/tile_renderer_top.sv
// Background tile renderer with its own VGA timing.
// Both VRAMs are external with one clock read latency. H_RES multiple of 8.
`timescale 1ns/1ps
`default_nettype none

module tile_renderer_top #(
    parameter int H_RES  = 320,
    parameter int V_RES  = 240,
    parameter int H_FP   = 23,
    parameter int H_SYNC = 28,
    parameter int H_BP   = 45,
    parameter int V_FP   = 6,
    parameter int V_SYNC = 3,
    parameter int V_BP   = 20,
    parameter bit H_POL  = 1'b0,   // 0 active low
    parameter bit V_POL  = 1'b0
) (
    input  wire                  vga_clk,
    input  wire                  i_rst_n,
    output logic                 o_hsync,
    output logic                 o_vsync,
    output logic                 o_de,
    output tile_pkg::rgb332_t    o_rgb,
    output tile_pkg::vram_addr_t o_vram8_addr,
    input  wire [7:0]            i_vram8_q,
    output tile_pkg::vram_addr_t o_vram32_addr,
    input  wire [31:0]           i_vram32_q
);

    video_timing_pkg::scan_pos_t pos;
    tile_pkg::tile_line_t        fetched_line;
    tile_pkg::tile_line_t        cur_line;
    logic                        load;
    logic                        swap;

    video_timing #(
        .H_RES  (H_RES),
        .V_RES  (V_RES),
        .H_FP   (H_FP),
        .H_SYNC (H_SYNC),
        .H_BP   (H_BP),
        .V_FP   (V_FP),
        .V_SYNC (V_SYNC),
        .V_BP   (V_BP),
        .H_POL  (H_POL),
        .V_POL  (V_POL)
    ) u_timing (
        .i_rst_n (i_rst_n),
        .vga_clk (vga_clk),
        .o_pos   (pos)
    );

    tile_fetcher u_fetcher (
        .vga_clk       (vga_clk),
        .i_rst_n       (i_rst_n),
        .i_pos         (pos),
        .o_vram8_addr  (o_vram8_addr),
        .i_vram8_q     (i_vram8_q),
        .o_vram32_addr (o_vram32_addr),
        .i_vram32_q    (i_vram32_q),
        .o_line        (fetched_line),
        .o_load        (load),
        .o_swap        (swap)
    );

    tile_line_buffer u_buffer (
        .vga_clk (vga_clk),
        .i_rst_n (i_rst_n),
        .i_line  (fetched_line),
        .i_load  (load),
        .i_swap  (swap),
        .o_cur   (cur_line)
    );

    pixel_out #(
        .H_POL (H_POL),
        .V_POL (V_POL)
    ) u_pixel (
        .vga_clk (vga_clk),
        .i_rst_n (i_rst_n),
        .i_pos   (pos),
        .i_cur   (cur_line),
        .o_hsync (o_hsync),
        .o_vsync (o_vsync),
        .o_de    (o_de),
        .o_rgb   (o_rgb)
    );

endmodule

`default_nettype wire

// File: verification/tb_tile_renderer.sv
// Testbench for the tile renderer on a 32x16 raster with active-low syncs.
// VRAM models answer one clock after the address. Their data changes on the falling edge.
// Tile entries cover every visible tile. All other VRAM words hold seeded random data.
`timescale 1ns/1ps
`default_nettype none

module tb_tile_renderer;

    localparam int H_RES       = 32;
    localparam int V_RES       = 16;
    localparam int H_FP        = 4;
    localparam int H_SYNC      = 4;
    localparam int H_BP        = 8;
    localparam int V_FP        = 2;
    localparam int V_SYNC      = 2;
    localparam int V_BP        = 2;
    localparam bit H_POL       = 1'b0;
    localparam bit V_POL       = 1'b0;
    localparam int LINE_CLKS   = H_RES + H_FP + H_SYNC + H_BP;
    localparam int FRAME_LINES = V_RES + V_FP + V_SYNC + V_BP;
    localparam int FRAME_CLKS  = LINE_CLKS * FRAME_LINES;
    localparam int RST_CYCLES  = 8;
    localparam int FRAMES      = 2;
    localparam int MAX_CYCLES  = RST_CYCLES + FRAMES * FRAME_CLKS + 4 * LINE_CLKS;
    localparam int VRAM_DEPTH  = 1 << tile_pkg::VRAM_AW;
    localparam int N_TILES     = 8;

    typedef struct packed {
        logic [5:0]  col;   // tile column in the map
        logic [2:0]  trow;  // tile row in the map
        logic [7:0]  tile;
        logic [7:0]  color;
        logic [31:0] pat0;  // rows 0,1 and 4,5 of the tile
        logic [31:0] pat1;  // rows 2,3 and 6,7
        logic [31:0] pal;
    } tile_entry_t;

    logic                 vga_clk = 1'b0;
    logic                 i_rst_n;
    logic                 o_hsync;
    logic                 o_vsync;
    logic                 o_de;
    tile_pkg::rgb332_t    o_rgb;
    tile_pkg::vram_addr_t o_vram8_addr;
    tile_pkg::vram_addr_t o_vram32_addr;
    logic [7:0]           vram8_q = 8'h00;
    logic [31:0]          vram32_q = 32'h0;
    tile_pkg::vram_addr_t addr8_q = '0;
    tile_pkg::vram_addr_t addr32_q = '0;

    logic [7:0]  vram8 [VRAM_DEPTH];
    logic [31:0] vram32 [VRAM_DEPTH];
    tile_entry_t tiles [N_TILES];

    int   cycles = 0;
    int   checks = 0;
    int   value_errs = 0;
    int   other_errs = 0;
    int   hs_width = 0;
    int   vs_lines = 0;
    int   lines = 0;
    int   de_run = 0;
    int   de_lines = 0;
    int   row = 0;
    int   frames_checked = 0;
    int   parity_hits = 0;
    logic frame_seen = 1'b0;
    logic hs_prev = 1'b0;
    logic vs_prev = 1'b0;
    logic de_prev = 1'b0;

    always #5 vga_clk = ~vga_clk;

    tile_renderer_top #(
        .H_RES  (H_RES),
        .V_RES  (V_RES),
        .H_FP   (H_FP),
        .H_SYNC (H_SYNC),
        .H_BP   (H_BP),
        .V_FP   (V_FP),
        .V_SYNC (V_SYNC),
        .V_BP   (V_BP),
        .H_POL  (H_POL),
        .V_POL  (V_POL)
    ) u_dut (
        .vga_clk       (vga_clk),
        .i_rst_n       (i_rst_n),
        .o_hsync       (o_hsync),
        .o_vsync       (o_vsync),
        .o_de          (o_de),
        .o_rgb         (o_rgb),
        .o_vram8_addr  (o_vram8_addr),
        .i_vram8_q     (vram8_q),
        .o_vram32_addr (o_vram32_addr),
        .i_vram32_q    (vram32_q)
    );

    // address taken at the clock edge, data shown half a clock later
    always @(posedge vga_clk) begin
        addr8_q  <= o_vram8_addr;
        addr32_q <= o_vram32_addr;
    end

    always @(negedge vga_clk) begin
        vram8_q  <= vram8[addr8_q];
        vram32_q <= vram32[addr32_q];
    end

    task automatic compare_hex(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        checks++;
        assert (got === want) else begin
            $display("FAIL %s got 0x%0h expected 0x%0h (cycle %0d)", name, got, want, cycles);
            value_errs++;
        end
    endtask

    task automatic require(input bit cond, input string what);
        checks++;
        assert (cond) else begin
            $display("ERROR %s", what);
            other_errs++;
        end
    endtask

    task automatic fill_memories;
        tile_pkg::vram_addr_t a;
        for (int i = 0; i < VRAM_DEPTH; i++) begin
            a         = tile_pkg::vram_addr_t'(i);
            vram8[a]  = 8'($urandom);
            vram32[a] = $urandom;
        end
    endtask

    task automatic define_tiles;
        tiles[0] = '{6'd0, 3'd0, 8'h05, 8'h00, 32'h1B1B_E4E4, 32'h0000_FFFF, 32'hE01C_03FF};
        tiles[1] = '{6'd1, 3'd0, 8'h2A, 8'h40, 32'hAAAA_5555, 32'hFFFF_0000, 32'h4992_B6DB};
        tiles[2] = '{6'd2, 3'd0, 8'h7F, 8'h81, 32'h0F0F_F0F0, 32'h3C3C_C3C3, 32'h2468_ACE1};
        tiles[3] = '{6'd3, 3'd0, 8'hC3, 8'hFF, 32'h1234_5678, 32'h9ABC_DEF0, 32'hFF00_8040};
        tiles[4] = '{6'd0, 3'd1, 8'h10, 8'h12, 32'hE4E4_1B1B, 32'h5A5A_A5A5, 32'h6D92_24DB};
        tiles[5] = '{6'd1, 3'd1, 8'h99, 8'h34, 32'h0123_4567, 32'h89AB_CDEF, 32'hC0A8_3F17};
        tiles[6] = '{6'd2, 3'd1, 8'hFE, 8'h56, 32'hFFFF_FFFF, 32'h0000_0000, 32'h1122_3344};
        tiles[7] = '{6'd3, 3'd1, 8'h01, 8'h78, 32'h3333_CCCC, 32'h6666_9999, 32'h8B5D_F07A};
    endtask

    task automatic write_tiles;
        tile_pkg::vram_addr_t a;
        int                   map_ofs;
        for (int i = 0; i < N_TILES; i++) begin
            map_ofs   = int'(tiles[i].trow) * tile_pkg::MAP_STRIDE + int'(tiles[i].col);
            a         = tile_pkg::vram_addr_t'(map_ofs);
            vram8[a]  = tiles[i].tile;
            a         = tile_pkg::vram_addr_t'(tile_pkg::COLOR_MAP_BASE + map_ofs);
            vram8[a]  = tiles[i].color;
            // word w holds rows 2w and 2w+1
            for (int w = 0; w < tile_pkg::WORDS_PER_TILE; w++) begin
                a         = tile_pkg::vram_addr_t'(int'(tiles[i].tile) * 4 + w);
                vram32[a] = (w % 2 == 0) ? tiles[i].pat0 : tiles[i].pat1;
            end
            a         = tile_pkg::vram_addr_t'(tile_pkg::PALETTE_BASE + int'(tiles[i].color));
            vram32[a] = tiles[i].pal;
        end
    endtask

    // colour of visible column n on visible row r
    function automatic logic [7:0] expected_pixel(input int n, input int r);
        tile_entry_t e;
        logic [31:0] word;
        logic [31:0] bits;
        logic [1:0]  code;
        int          k;
        int          top;
        e = '0;
        for (int i = 0; i < N_TILES; i++) begin
            if (int'(tiles[i].col) == n / 8 && int'(tiles[i].trow) == r / 8) begin
                e = tiles[i];
            end
        end
        word = ((r / 2) % 2 == 0) ? e.pat0 : e.pat1;
        k    = n % 8;
        top  = (r % 2 == 0) ? 31 : 15;   // odd rows read the low half
        bits = word >> (top - 1 - 2 * k);
        code = {bits[0], bits[1]};       // low bit is word bit top-2k
        case (code)
            2'd0:    return e.pal[31:24];
            2'd1:    return e.pal[23:16];
            2'd2:    return e.pal[15:8];
            default: return e.pal[7:0];
        endcase
    endfunction

    task automatic verify_idle;
        compare_hex("o_de", 32'(o_de), 32'h0);
        compare_hex("o_rgb", 32'(o_rgb), 32'h0);
        compare_hex("o_hsync", 32'(o_hsync), 32'(!H_POL));
        compare_hex("o_vsync", 32'(o_vsync), 32'(!V_POL));
    endtask

    task automatic track_raster;
        logic hs_act;
        logic vs_act;
        hs_act = (o_hsync == H_POL);
        vs_act = (o_vsync == V_POL);
        if (hs_act) begin
            if (!hs_prev) begin
                lines++;
                if (vs_act) begin
                    vs_lines++;
                end
            end
            hs_width++;
        end else if (hs_prev) begin
            compare_hex("o_hsync width", hs_width, H_SYNC);
            hs_width = 0;
        end
        if (vs_act && !vs_prev) begin
            if (frame_seen) begin
                compare_hex("lines per frame", lines, FRAME_LINES);
                compare_hex("o_de lines per frame", de_lines, V_RES);
                frames_checked++;
            end
            frame_seen = 1'b1;
            lines      = 0;
            de_lines   = 0;
            row        = 0;
        end else if (!vs_act && vs_prev) begin
            compare_hex("o_vsync width in lines", vs_lines, V_SYNC);
            vs_lines = 0;
        end
        if (o_de) begin
            compare_hex($sformatf("o_rgb col %0d row %0d", de_run, row), 32'(o_rgb),
                        32'(expected_pixel(de_run, row)));
            // odd row shown correctly where its colour differs from the even row
            if (row % 2 == 1 && 8'(o_rgb) === expected_pixel(de_run, row) &&
                expected_pixel(de_run, row) != expected_pixel(de_run, row - 1)) begin
                parity_hits++;
            end
            de_run++;
        end else begin
            compare_hex("o_rgb while o_de low", 32'(o_rgb), 32'h0);
            if (de_prev) begin
                compare_hex("o_de run length", de_run, H_RES);
                de_lines++;
                row++;
                de_run = 0;
            end
        end
        hs_prev = hs_act;
        vs_prev = vs_act;
        de_prev = o_de;
    endtask

    // outputs are sampled half a clock after they change
    always @(negedge vga_clk) begin
        cycles = cycles + 1;
        if (cycles <= RST_CYCLES + 1) begin
            verify_idle;
        end else begin
            track_raster;
        end
    end

    initial begin
        i_rst_n = 1'b0;
        void'($urandom(61));
        fill_memories;
        define_tiles;
        write_tiles;
        repeat (RST_CYCLES) @(negedge vga_clk);
        i_rst_n = 1'b1;
        while (frames_checked < FRAMES && cycles < MAX_CYCLES) begin
            @(posedge vga_clk);
        end
        require(frames_checked >= FRAMES,
                "timeout: the cycle limit was reached before two full frames were seen");
        require(parity_hits > 0, "no odd row showed a colour different from the row above it");
        $display("checks %0d, value errors %0d, other errors %0d",
                 checks, value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
src/video_timing_pkg.sv
src/tile_pkg.sv
src/video_timing.sv
src/tile_fetcher.sv
src/tile_line_buffer.sv
src/pixel_out.sv
src/tile_renderer_top.sv
verification/tb_tile_renderer.sv

// File: Makefile
VERILATOR  ?= verilator
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
TOP        := tb_tile_renderer
FILELIST   := list.f
BIN        := obj_dir/V$(TOP)
PASS_MSG   := NO ERRORS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
